//--- logic/sof_pkg.sv
package sof_pkg;

    // sample word geometry
    localparam int NUM_CHUNKS    = 5;
    localparam int CHUNK_W       = 8;
    localparam int SAMPLE_W      = NUM_CHUNKS * CHUNK_W;

    // a chunk is active when this many of its bits are set
    localparam int ACTIVE_THRESH = 5;
    localparam int ONES_W        = $clog2(CHUNK_W + 1);

    localparam int WORD_IDX_W    = 12;

    // output queue sizing
    localparam int QUEUE_DEPTH   = 8;
    localparam int QPTR_W        = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W        = QPTR_W + 1;   // holds 0 to QUEUE_DEPTH inclusive

    typedef logic [SAMPLE_W-1:0]   sample_word_t;
    typedef logic [NUM_CHUNKS-1:0] chunk_flags_t;
    typedef logic [2:0]            chunk_idx_t;
    typedef logic [1:0]            start_count_t;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;   // wraps after 4096 words

    // one detected start of frame
    typedef struct packed {
        word_idx_t  word_idx;
        chunk_idx_t chunk_idx;
    } sof_entry_t;

    // registered chunk activity handed from the input side to the decoder
    typedef struct packed {
        chunk_flags_t active;
        word_idx_t    word_idx;
        logic         capture;
    } flag_bundle_t;

    // decoder result, loc_2 is only meaningful when count is 2
    typedef struct packed {
        chunk_idx_t   loc_1;
        chunk_idx_t   loc_2;
        start_count_t count;
        logic         trailing;
    } start_info_t;

endpackage

//--- logic/chunk_flagger.sv
`timescale 1ns/1ps

module chunk_flagger import sof_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  sample_word_t sample,
    input  logic         capture_en,
    output flag_bundle_t flags
);

    logic [ONES_W-1:0] ones [NUM_CHUNKS];
    chunk_flags_t      active_c;
    word_idx_t         word_cnt;

    // population count per chunk, then compare against the threshold
    always_comb begin
        for (int c = 0; c < NUM_CHUNKS; c++) begin
            ones[c] = '0;
            for (int b = 0; b < CHUNK_W; b++) begin
                ones[c] = ones[c] + ONES_W'(sample[c*CHUNK_W + b]);
            end
            active_c[c] = (ones[c] >= ONES_W'(ACTIVE_THRESH));
        end
    end

    // word_cnt always holds the index the next captured word will get
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
        end else if (capture_en) begin
            word_cnt <= word_cnt + 1'b1;
        end else begin
            word_cnt <= '0;   // restart numbering on the next enable
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (capture_en) begin
            flags.active   <= active_c;
            flags.word_idx <= word_cnt;
            flags.capture  <= 1'b1;
        end else begin
            flags <= '0;
        end
    end

    // the decoder relies on idle words carrying no activity at all
    a_idle_no_flags: assert property (
        @(posedge clk) disable iff (!rst_n)
        !flags.capture |-> (flags.active == '0 && flags.word_idx == '0)
    ) else $error("chunk flags set while capture is low");

    // consecutive captured words are numbered back to back
    a_word_idx_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        flags.capture ##1 flags.capture |-> flags.word_idx == $past(flags.word_idx) + 1'b1
    ) else $error("word index skipped");

endmodule

//--- logic/start_frame_decoder.sv
`timescale 1ns/1ps

module start_frame_decoder import sof_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  flag_bundle_t flags,
    output start_info_t  starts
);

    logic [1:0]            hist;      // previous word, [1] is chunk 4 and [0] is chunk 3
    logic [NUM_CHUNKS+1:0] window;
    chunk_flags_t          marks;
    logic [2:0]            mark_sum;

    // history comes from the top two chunks, cleared whenever capture is off
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist <= '0;
        end else if (flags.capture) begin
            hist[1] <= flags.active[NUM_CHUNKS-1];
            hist[0] <= flags.active[NUM_CHUNKS-2];
        end else begin
            hist <= '0;
        end
    end

    // two bits of history below the five chunks of the current word
    always_comb begin
        window[1:0] = hist;
        for (int ii = 0; ii < NUM_CHUNKS; ii++) begin
            window[ii+2] = flags.active[ii];
        end
    end

    // a start is an active chunk sitting above two quiet ones
    always_comb begin
        for (int ii = 0; ii < NUM_CHUNKS; ii++) begin
            marks[ii] = window[ii+2] & ~window[ii+1] & ~window[ii];
        end

        mark_sum = '0;
        for (int ii = 0; ii < NUM_CHUNKS; ii++) begin
            mark_sum = mark_sum + 3'(marks[ii]);
        end
    end

    always_comb begin
        starts.count    = start_count_t'(mark_sum);
        starts.trailing = window[NUM_CHUNKS+1] | window[NUM_CHUNKS];

        // only these mark patterns can occur with two quiet chunks before each start
        case (marks)
            5'b00001: begin
                starts.loc_1 = 3'd0;
                starts.loc_2 = 3'd0;
            end
            5'b01001: begin
                starts.loc_1 = 3'd0;
                starts.loc_2 = 3'd3;
            end
            5'b10001: begin
                starts.loc_1 = 3'd0;
                starts.loc_2 = 3'd4;
            end
            5'b00010: begin
                starts.loc_1 = 3'd1;
                starts.loc_2 = 3'd0;
            end
            5'b10010: begin
                starts.loc_1 = 3'd1;
                starts.loc_2 = 3'd4;
            end
            5'b00100: begin
                starts.loc_1 = 3'd2;
                starts.loc_2 = 3'd0;
            end
            5'b01000: begin
                starts.loc_1 = 3'd3;
                starts.loc_2 = 3'd0;
            end
            5'b10000: begin
                starts.loc_1 = 3'd4;
                starts.loc_2 = 3'd0;
            end
            default: begin
                starts.loc_1 = 3'd0;
                starts.loc_2 = 3'd0;
            end
        endcase
    end

    // the queue writes at most two entries per word
    a_max_two_starts: assert property (
        @(posedge clk) disable iff (!rst_n)
        mark_sum <= 3'd2
    ) else $error("more than two starts decoded in one word");

    // the previous word's history must not leak into an idle cycle
    a_idle_no_starts: assert property (
        @(posedge clk) disable iff (!rst_n)
        !flags.capture |-> starts.count == '0
    ) else $error("start decoded while capture is low");

endmodule

//--- logic/sof_entry_queue.sv
`timescale 1ns/1ps

module sof_entry_queue import sof_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  flag_bundle_t flags,
    input  start_info_t  starts,
    input  logic         rd_en,
    output sof_entry_t   entry,
    output logic         entry_valid,
    output logic         line_active,
    output logic         overflow
);

    sof_entry_t        mem [QUEUE_DEPTH];
    sof_entry_t        entry_lo;
    sof_entry_t        entry_hi;
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;
    logic [QCNT_W-1:0] free_slots;
    logic              do_read;
    logic              do_write;
    logic              no_room;

    always_comb begin
        entry_lo.word_idx  = flags.word_idx;
        entry_lo.chunk_idx = starts.loc_1;
        entry_hi.word_idx  = flags.word_idx;
        entry_hi.chunk_idx = starts.loc_2;
    end

    always_comb begin
        do_read    = rd_en && (count != '0);   // reads on an empty queue are dropped
        // a read on the same edge frees its slot before the write is checked
        free_slots = QCNT_W'(QUEUE_DEPTH) - count + QCNT_W'(do_read);
        no_room    = QCNT_W'(starts.count) > free_slots;
        do_write   = (starts.count != '0) && !no_room;
    end

    // the lower start always takes the first slot so it leaves the queue first
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= entry_lo;
            if (starts.count == 2'd2) begin
                mem[wr_ptr + 1'b1] <= entry_hi;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + QPTR_W'(starts.count);
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count - QCNT_W'(do_read) + (do_write ? QCNT_W'(starts.count) : '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow    <= 1'b0;
            line_active <= 1'b0;
        end else begin
            if (no_room) begin
                overflow <= 1'b1;   // sticky until reset
            end
            line_active <= flags.capture & starts.trailing;
        end
    end

    // first word fall through keeps the head entry on the output
    assign entry       = mem[rd_ptr];
    assign entry_valid = (count != '0);

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= QCNT_W'(QUEUE_DEPTH)
    ) else $error("queue holds more than QUEUE_DEPTH entries");

    // an empty queue must keep its head where it is whatever rd_en does
    a_read_not_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        (count == '0) |=> (rd_ptr == $past(rd_ptr))
    ) else $error("read accepted on an empty queue");

endmodule

//--- logic/sof_detector_top.sv
`timescale 1ns/1ps

module sof_detector_top import sof_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  sample_word_t sample,
    input  logic         capture_en,
    input  logic         rd_en,
    output sof_entry_t   entry,
    output logic         entry_valid,
    output logic         line_active,
    output logic         overflow
);

    flag_bundle_t flags_q;    // registered chunk activity and word index
    start_info_t  starts_c;   // combinational decode of flags_q

    chunk_flagger u_chunk_flagger (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample     (sample),
        .capture_en (capture_en),
        .flags      (flags_q)
    );

    start_frame_decoder u_start_frame_decoder (
        .clk    (clk),
        .rst_n  (rst_n),
        .flags  (flags_q),
        .starts (starts_c)
    );

    // the word index reaches the queue alongside the decode in flags_q
    sof_entry_queue u_sof_entry_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .flags       (flags_q),
        .starts      (starts_c),
        .rd_en       (rd_en),
        .entry       (entry),
        .entry_valid (entry_valid),
        .line_active (line_active),
        .overflow    (overflow)
    );

endmodule

//--- testbench/sof_tb_tasks.svh
`ifndef SOF_TB_TASKS_SVH
`define SOF_TB_TASKS_SVH

task automatic check_entry(input string name, input sof_entry_t got, input sof_entry_t exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH at %0t ns: %s got word %0d chunk %0d, expected word %0d chunk %0d",
                 $time, name, got.word_idx, got.chunk_idx, exp.word_idx, exp.chunk_idx);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH at %0t ns: %s got %b, expected %b", $time, name, got, exp);
    end
endtask

// every output against the reference model after the edge has settled
task automatic compare_outputs();
    check_bit("entry_valid", entry_valid, m_queue.size() != 0);
    if (m_queue.size() != 0) begin
        check_entry("entry", entry, m_queue[0]);   // head entry only exists when not empty
    end
    check_bit("line_active", line_active, m_line_active);
    check_bit("overflow", overflow, m_overflow);
endtask

// active chunks carry five set bits and quiet ones four, right at the threshold
function automatic sample_word_t build_word(input chunk_flags_t act);
    sample_word_t w;
    for (int c = 0; c < NUM_CHUNKS; c++) begin
        w[c*CHUNK_W +: CHUNK_W] = act[c] ? 8'hf8 : 8'h17;
    end
    return w;
endfunction

// one clock cycle: predict the edge, drive new inputs, compare at the falling edge
task automatic step_cycle(input sample_word_t smp, input logic cap, input logic rd);
    @(posedge clk);
    predict_edge(capture_en, sample, rd_en);   // the values the DUT took on this edge
    sample     <= smp;
    capture_en <= cap;
    rd_en      <= rd;
    @(negedge clk);
    compare_outputs();
endtask

task automatic apply_reset();
    @(posedge clk);
    rst_n      <= 1'b0;
    sample     <= '0;
    capture_en <= 1'b0;
    rd_en      <= 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_bit("entry_valid", entry_valid, 1'b0);
    check_bit("line_active", line_active, 1'b0);
    check_bit("overflow", overflow, 1'b0);
    @(posedge clk);
    rst_n <= 1'b1;
    clear_reference();
endtask

task automatic wait_for_entry(input int max_cycles);
    int waited;
    waited = 0;
    while (entry_valid !== 1'b1 && waited < max_cycles) begin
        step_cycle('0, 1'b0, 1'b0);
        waited++;
    end
    if (entry_valid !== 1'b1) begin
        failure_count++;
        $display("ERROR at %0t ns: no entry became valid within %0d cycles", $time, max_cycles);
    end
endtask

// the read pulse is taken on the edge after it is driven, so two cycles per entry
task automatic pop_and_compare(input int word, input int chunk);
    sof_entry_t exp;
    exp.word_idx  = word_idx_t'(word);
    exp.chunk_idx = chunk_idx_t'(chunk);
    wait_for_entry(8);
    check_entry("entry", entry, exp);
    step_cycle('0, 1'b0, 1'b1);
    step_cycle('0, 1'b0, 1'b0);
endtask

task automatic drain_queue(input int max_cycles);
    int waited;
    waited = 0;
    while (entry_valid === 1'b1 && waited < max_cycles) begin
        step_cycle('0, 1'b0, 1'b1);
        waited++;
    end
    step_cycle('0, 1'b0, 1'b0);
    if (entry_valid !== 1'b0) begin
        failure_count++;
        $display("ERROR at %0t ns: queue did not drain within %0d cycles", $time, max_cycles);
    end
endtask

`endif

//--- testbench/sof_detector_tb.sv
`timescale 1ns/1ps

module sof_detector_tb import sof_pkg::*; ();

    logic         clk;
    logic         rst_n;
    sample_word_t sample;
    logic         capture_en;
    logic         rd_en;
    sof_entry_t   entry;
    logic         entry_valid;
    logic         line_active;
    logic         overflow;

    int     mismatch_count;
    int     failure_count;
    integer seed;

    // reference model state
    sof_entry_t   m_queue [$];
    logic         m_overflow;
    logic         m_line_active;
    logic [1:0]   m_hist;        // previous word, [1] is chunk 4 and [0] is chunk 3
    logic         m_cap;         // word registered by the input side
    chunk_flags_t m_active;
    word_idx_t    m_word;
    word_idx_t    m_next_word;

    sof_detector_top u_sof_detector_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample      (sample),
        .capture_en  (capture_en),
        .rd_en       (rd_en),
        .entry       (entry),
        .entry_valid (entry_valid),
        .line_active (line_active),
        .overflow    (overflow)
    );

    `include "sof_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic chunk_flags_t chunk_activity(input sample_word_t smp);
        chunk_flags_t act;
        for (int c = 0; c < NUM_CHUNKS; c++) begin
            act[c] = $countones(smp[c*CHUNK_W +: CHUNK_W]) >= ACTIVE_THRESH;
        end
        return act;
    endfunction

    task automatic clear_reference();
        m_queue.delete();
        m_overflow    = 1'b0;
        m_line_active = 1'b0;
        m_hist        = 2'b00;
        m_cap         = 1'b0;
        m_active      = '0;
        m_word        = '0;
        m_next_word   = '0;
    endtask

    // the queue stage works on the older word, so it is updated before the input side
    task automatic predict_edge(input logic cap, input sample_word_t smp, input logic rd);
        sof_entry_t found [$];
        sof_entry_t ent;
        int         quiet;
        int         free_slots;
        logic       do_read;

        quiet = m_hist[1] ? 0 : (m_hist[0] ? 1 : 2);   // quiet chunks right below chunk 0
        for (int c = 0; c < NUM_CHUNKS; c++) begin
            if (m_active[c] && quiet >= 2) begin
                ent.word_idx  = m_word;
                ent.chunk_idx = chunk_idx_t'(c);
                found.push_back(ent);
            end
            quiet = m_active[c] ? 0 : quiet + 1;
        end

        do_read    = rd && (m_queue.size() != 0);
        free_slots = QUEUE_DEPTH - m_queue.size() + (do_read ? 1 : 0);
        if (do_read) begin
            void'(m_queue.pop_front());
        end
        if (found.size() > free_slots) begin
            m_overflow = 1'b1;   // the whole word is dropped
        end else begin
            foreach (found[i]) begin
                m_queue.push_back(found[i]);
            end
        end
        m_line_active = m_cap && (m_active[NUM_CHUNKS-1] || m_active[NUM_CHUNKS-2]);
        m_hist        = m_cap ? {m_active[NUM_CHUNKS-1], m_active[NUM_CHUNKS-2]} : 2'b00;

        if (cap) begin
            m_cap       = 1'b1;
            m_active    = chunk_activity(smp);
            m_word      = m_next_word;
            m_next_word = m_next_word + 1'b1;
        end else begin
            m_cap       = 1'b0;
            m_active    = '0;
            m_word      = '0;
            m_next_word = '0;
        end
    endtask

    task automatic single_start();
        step_cycle(build_word(5'b00100), 1'b1, 1'b0);
        step_cycle('0, 1'b0, 1'b0);
        pop_and_compare(0, 2);
        check_bit("entry_valid", entry_valid, 1'b0);
    endtask

    task automatic two_starts_per_word();
        step_cycle(build_word(5'b01001), 1'b1, 1'b0);
        step_cycle(build_word(5'b10010), 1'b1, 1'b0);
        step_cycle('0, 1'b0, 1'b0);
        pop_and_compare(0, 0);
        pop_and_compare(0, 3);
        pop_and_compare(1, 1);
        pop_and_compare(1, 4);
    endtask

    task automatic word_boundary();
        step_cycle(build_word(5'b10000), 1'b1, 1'b0);
        step_cycle(build_word(5'b00001), 1'b1, 1'b0);   // chunk 0 sits above the old chunk 4
        step_cycle(build_word(5'b00001), 1'b1, 1'b0);
        check_bit("line_active", line_active, 1'b1);
        step_cycle(build_word(5'b01000), 1'b1, 1'b0);
        check_bit("line_active", line_active, 1'b0);
        step_cycle(build_word(5'b00001), 1'b1, 1'b0);   // blocked by the old chunk 3
        step_cycle('0, 1'b0, 1'b0);
        check_bit("line_active", line_active, 1'b1);
        pop_and_compare(0, 4);
        pop_and_compare(2, 0);
        pop_and_compare(3, 3);
        check_bit("entry_valid", entry_valid, 1'b0);
    endtask

    task automatic disable_clears_history();
        step_cycle(build_word(5'b10000), 1'b1, 1'b0);
        step_cycle('0, 1'b0, 1'b0);
        step_cycle(build_word(5'b00001), 1'b1, 1'b0);
        step_cycle('0, 1'b0, 1'b0);
        pop_and_compare(0, 4);
        pop_and_compare(0, 0);   // numbering restarts after the gap
    endtask

    task automatic overflow_and_drain();
        for (int i = 0; i < 3; i++) begin
            step_cycle(build_word(5'b01001), 1'b1, 1'b0);
            step_cycle(build_word(5'b00000), 1'b1, 1'b0);
        end
        step_cycle(build_word(5'b00100), 1'b1, 1'b0);   // word 6 brings the count to 7
        step_cycle(build_word(5'b01001), 1'b1, 1'b0);   // needs two slots with one free
        step_cycle(build_word(5'b00100), 1'b1, 1'b0);
        step_cycle(build_word(5'b00001), 1'b1, 1'b0);   // queue full
        step_cycle('0, 1'b0, 1'b0);
        step_cycle('0, 1'b0, 1'b0);
        check_bit("overflow", overflow, 1'b1);
        check_bit("entry_valid", entry_valid, 1'b1);
        pop_and_compare(0, 0);
        pop_and_compare(0, 3);
        pop_and_compare(2, 0);
        pop_and_compare(2, 3);
        pop_and_compare(4, 0);
        pop_and_compare(4, 3);
        pop_and_compare(6, 2);
        pop_and_compare(8, 2);
        check_bit("entry_valid", entry_valid, 1'b0);
        check_bit("overflow", overflow, 1'b1);
    endtask

    task automatic random_stream();
        logic [31:0]  rnd_hi;
        logic [31:0]  rnd_lo;
        logic [31:0]  ctl;
        sample_word_t smp;
        for (int i = 0; i < 200; i++) begin
            rnd_hi = $random(seed);
            rnd_lo = $random(seed);
            ctl    = $random(seed);
            smp    = {rnd_hi[7:0], rnd_lo};
            // capture drops about one cycle in eight, reads come half the time
            step_cycle(smp, ctl[2:0] != 3'b000, ctl[3]);
        end
        drain_queue(20);
    endtask

    initial begin
        rst_n          = 1'b0;
        sample         = '0;
        capture_en     = 1'b0;
        rd_en          = 1'b0;
        mismatch_count = 0;
        failure_count  = 0;
        seed           = 91;
        clear_reference();

        apply_reset();
        single_start();
        two_starts_per_word();
        word_boundary();
        disable_clears_history();
        overflow_and_drain();
        apply_reset();
        random_stream();

        $display("end of run: %0d mismatches, %0d other errors", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- sof_detector_top.f
+incdir+testbench
logic/sof_pkg.sv
logic/chunk_flagger.sv
logic/start_frame_decoder.sv
logic/sof_entry_queue.sv
logic/sof_detector_top.sv
testbench/sof_detector_tb.sv
